// ==== include/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// Data path width for RV32I
`define RV_XLEN 32

// log2 of the register count
`define RV_REG_ADDR_W 5

`endif

// ==== source/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

    // Plain vectors for the widths that carry a meaning
    typedef logic [`RV_XLEN-1:0] word_t;        // Operands, results, immediates
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t; // Register index
    typedef logic [31:0] instr_t;                // Raw instruction word

    // ALU operations supported by the slice
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,  // Signed compare
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    // Write-back source, codes follow the register file input mux
    typedef enum logic [1:0] {
        WB_NONE  = 2'd0,
        WB_MEM   = 2'd1, // Load data
        WB_FETCH = 2'd2, // Return address from fetch
        WB_ALU   = 2'd3
    } wb_src_t;

endpackage

// ==== source/regfile_if.sv ====
`timescale 1ns/1ps

// Register file controls produced by the decoder
interface regfile_if import rv_pkg::*; ();

    reg_addr_t address_r1;    // rs1
    reg_addr_t address_r2;    // rs2
    reg_addr_t address_rd;    // rd
    logic      en_read_1;
    logic      en_read_2;
    logic      en_write;
    wb_src_t   data_in_control; // Write-back mux select

    modport decoder (
        output address_r1, address_r2, address_rd,
        output en_read_1, en_read_2, en_write,
        output data_in_control
    );

    modport regfile (
        input address_r1, address_r2, address_rd,
        input en_read_1, en_read_2, en_write,
        input data_in_control
    );

endinterface

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import rv_pkg::*;
(
    input  instr_t            instruction,
    regfile_if.decoder        rf,
    output alu_op_t           alu_op,
    output word_t             imm,
    output logic              use_imm    // Operand B from immediate
);

    // Major opcodes of the supported classes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b30; // Selects sub over add, sra over srl
    alu_op_t    funct_op;   // ALU op implied by funct3 alone

    assign opcode     = instruction[6:0];
    assign funct3     = instruction[14:12];
    assign funct7_b30 = instruction[30];

    // Register fields sit at fixed positions in every format
    assign rf.address_r1 = instruction[19:15];
    assign rf.address_r2 = instruction[24:20];
    assign rf.address_rd = instruction[11:7];

    always_comb begin : funct_map
        case (funct3)
            3'b000:  funct_op = ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            3'b111:  funct_op = ALU_AND;
            default: funct_op = ALU_ADD; // sltu not supported
        endcase
    end

    always_comb begin : decode
        rf.en_read_1       = 1'b0;
        rf.en_read_2       = 1'b0;
        rf.en_write        = 1'b0;
        rf.data_in_control = WB_NONE;
        alu_op             = ALU_ADD;    // Address add for load and store
        use_imm            = 1'b0;
        imm                = {{20{instruction[31]}}, instruction[31:20]}; // I-type

        case (opcode)
            OPC_OP: begin
                rf.en_read_1       = 1'b1;
                rf.en_read_2       = 1'b1;
                rf.en_write        = 1'b1;
                rf.data_in_control = WB_ALU;
                alu_op             = funct_op;
                if (funct3 == 3'b000 && funct7_b30)
                    alu_op = ALU_SUB;
                // sra is outside the subset, drop its write
                if (funct3 == 3'b101 && funct7_b30)
                    rf.en_write = 1'b0;
            end
            OPC_OP_IMM: begin
                rf.en_read_1       = 1'b1;
                rf.en_write        = 1'b1;
                rf.data_in_control = WB_ALU;
                alu_op             = funct_op;
                use_imm            = 1'b1;
            end
            OPC_LOAD: begin
                rf.en_read_1       = 1'b1;
                rf.en_write        = 1'b1;
                rf.data_in_control = WB_MEM; // Memory returns the load data
                use_imm            = 1'b1;
            end
            OPC_STORE: begin
                rf.en_read_1 = 1'b1;             // Base address
                rf.en_read_2 = 1'b1;             // Store data
                use_imm      = 1'b1;
                imm          = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            OPC_JAL: begin
                rf.en_write        = 1'b1;       // rd gets pc + 4, nothing read
                rf.data_in_control = WB_FETCH;
            end
            default: ; // Unknown opcode, all controls stay idle
        endcase
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module register_file
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,                        // Clears every register
    regfile_if.regfile  rf,
    input  logic        busy,                         // Freezes reads and writes
    input  word_t       data_in_frommemory,
    input  word_t       data_in_frominstructionfetch,
    input  word_t       data_in_fromalu,
    output word_t       data_out_r1,
    output word_t       data_out_r2
);

    word_t regs [`RV_NUM_REGS]; // Architectural registers
    word_t data_in;             // Selected write-back value
    logic  write_ok;

    // x0 is hardwired, writes to it vanish
    assign write_ok = rf.en_write && !busy && (rf.address_rd != '0);

    // Gated read, zero when disabled, frozen or x0
    function automatic word_t read_port(input reg_addr_t addr, input logic en);
        if (!en || busy || addr == '0)
            return '0;
        return regs[addr];
    endfunction

    always_comb begin : select_data_in
        case (rf.data_in_control)
            WB_MEM:   data_in = data_in_frommemory;
            WB_FETCH: data_in = data_in_frominstructionfetch;
            WB_ALU:   data_in = data_in_fromalu;
            default:  data_in = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (write_ok) begin
            regs[rf.address_rd] <= data_in; // Visible to reads next cycle
        end
    end

    always_comb begin : read_ports
        data_out_r1 = read_port(rf.address_r1, rf.en_read_1);
        data_out_r2 = read_port(rf.address_r2, rf.en_read_2);
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
    import rv_pkg::*;
(
    input  word_t   operand_a,  // rs1 value
    input  word_t   rs2_data,
    input  word_t   imm,
    input  logic    use_imm,
    input  alu_op_t alu_op,
    output word_t   result
);

    word_t      operand_b;
    logic [4:0] shamt;     // Only low 5 bits shift in RV32

    assign operand_b = use_imm ? imm : rs2_data;
    assign shamt     = operand_b[4:0];

    always_comb begin : compute
        case (alu_op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            // Signed compare, result is 0 or 1
            ALU_SLT: result = word_t'($signed(operand_a) < $signed(operand_b));
            ALU_SLL: result = operand_a << shamt;
            ALU_SRL: result = operand_a >> shamt; // Logical, zero fill
            default: result = '0;
        endcase
    end

endmodule

// ==== source/rv_datapath.sv ====
`timescale 1ns/1ps

module rv_datapath
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  instr_t instruction,
    input  logic   busy,        // Stalls the slice for the cycle
    input  word_t  mem_data,    // Load data
    input  word_t  pc_plus4,    // Return address for jal
    output word_t  alu_result,
    output word_t  store_data
);

    regfile_if rf_bus ();

    alu_op_t alu_op;
    word_t   imm;
    logic    use_imm;
    word_t   rs1_data;
    word_t   rs2_data;

    instr_decoder u_decoder (
        .instruction (instruction),
        .rf          (rf_bus),
        .alu_op      (alu_op),
        .imm         (imm),
        .use_imm     (use_imm)
    );

    register_file u_regfile (
        .clk                          (clk),
        .reset                        (reset),
        .rf                           (rf_bus),
        .busy                         (busy),
        .data_in_frommemory           (mem_data),
        .data_in_frominstructionfetch (pc_plus4),
        .data_in_fromalu              (alu_result), // ALU write-back loop
        .data_out_r1                  (rs1_data),
        .data_out_r2                  (rs2_data)
    );

    alu u_alu (
        .operand_a (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .result    (alu_result)
    );

    assign store_data = rs2_data; // rs2 doubles as store data

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 20; // 40 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== bench/rv_datapath_asserts.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_datapath_asserts
    import rv_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      busy,
    input logic      en_write,
    input wb_src_t   data_in_control,
    input reg_addr_t address_rd,
    input word_t     regs [`RV_NUM_REGS]  // Register file storage
);

    // A stalled write leaves its target untouched
    assert property (@(posedge clk) disable iff (reset)
        (busy && en_write) |=> regs[$past(address_rd)] == $past(regs[address_rd]))
        else $error("register changed by a write issued while busy");

    // x0 is hardwired, no write may ever reach its storage
    assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0)
        else $error("register x0 holds a nonzero value");

    assert property (@(posedge clk) disable iff (reset)
        en_write |-> (data_in_control != WB_NONE))
        else $error("write enabled with no write-back source");

endmodule

bind rv_datapath rv_datapath_asserts asserts0 (
    .clk             (clk),
    .reset           (reset),
    .busy            (busy),
    .en_write        (rf_bus.en_write),
    .data_in_control (rf_bus.data_in_control),
    .address_rd      (rf_bus.address_rd),
    .regs            (u_regfile.regs)
);

// ==== bench/rv_datapath_tb.sv ====
`timescale 1ns/1ps

module rv_datapath_tb
    import rv_pkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int RESET_LIMIT  = 10; // Cycles allowed for reset to drop
    localparam int EDGE_LIMIT   = 4;  // Clock changes allowed per edge wait

    // add x3, x1, x2 reads two registers that the trace has written
    localparam instr_t ADD_X3_X1_X2 = 32'h002081B3;

    logic   clk;
    logic   reset;
    instr_t instruction;
    logic   busy;
    word_t  mem_data;
    word_t  pc_plus4;
    word_t  alu_result;
    word_t  store_data;

    int check_count;
    int error_count;

    clock_gen clock0 (.clk(clk));

    rv_datapath dut0 (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .busy        (busy),
        .mem_data    (mem_data),
        .pc_plus4    (pc_plus4),
        .alu_result  (alu_result),
        .store_data  (store_data)
    );

    // Returns once clk has changed to level, ok stays low if it never does
    task automatic wait_clk(input logic level, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < EDGE_LIMIT && !ok; n++) begin
            @(clk);
            ok = (clk === level);
        end
    endtask

    task automatic compare_word(input string name, input word_t actual,
                                input word_t expected, output bit match);
        check_count++;
        match = (actual === expected);
        if (!match) begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    initial begin : main
        int          fd;
        int          code;
        int          step;
        string       text;
        string       fail_reason;
        bit          ok;
        bit          released;
        bit          alu_ok;
        bit          store_ok;
        logic [31:0] t_instr;
        logic [31:0] t_mem;
        logic [31:0] t_pc;
        logic [31:0] t_busy;
        logic [31:0] t_alu;
        logic [31:0] t_store;

        instruction = '0;                 // Opcode 0 decodes to no action
        busy        = 1'b0;
        mem_data    = '0;
        pc_plus4    = '0;
        reset       = 1'b1;
        check_count = 0;
        error_count = 0;
        step        = 0;
        fd          = 0;
        fail_reason = "";

        for (int c = 0; c < RESET_CYCLES && fail_reason == ""; c++) begin
            wait_clk(1'b1, ok);
            if (!ok)
                fail_reason = "clock stopped while reset was held";
        end
        reset <= 1'b0;

        released = 1'b0;
        for (int c = 0; c < RESET_LIMIT && !released; c++) begin
            wait_clk(1'b0, ok);
            released = ok && (reset === 1'b0);
        end
        if (!released && fail_reason == "")
            fail_reason = "reset did not release in time";

        if (fail_reason == "") begin
            fd = $fopen("bench/rv_datapath_trace.txt", "r");
            if (fd == 0)
                fail_reason = "trace file could not be opened";
        end

        // One trace line per cycle, driven at the rise, checked at the fall
        while (fail_reason == "" && !$feof(fd)) begin
            code = $fgets(text, fd);
            if (code == 0 || text[0] == "#")
                continue;
            code = $sscanf(text, "%h %h %h %h %h %h", t_instr, t_mem, t_pc, t_busy,
                           t_alu, t_store);
            if (code != 6)
                continue;                 // Blank line
            wait_clk(1'b1, ok);
            if (!ok) begin
                fail_reason = "timeout waiting for a rising clock edge";
                continue;
            end
            instruction <= t_instr;
            mem_data    <= t_mem;
            pc_plus4    <= t_pc;
            busy        <= t_busy[0];
            wait_clk(1'b0, ok);
            if (!ok) begin
                fail_reason = "timeout waiting for a falling clock edge";
                continue;
            end
            step++;
            compare_word("alu_result", alu_result, t_alu, alu_ok);
            compare_word("store_data", store_data, t_store, store_ok);
            $display("Step %0d: instruction %h busy %0d %s", step, t_instr, t_busy[0],
                     (alu_ok && store_ok) ? "ok" : "mismatch");
        end
        if (fd != 0)
            $fclose(fd);
        if (step == 0 && fail_reason == "")
            fail_reason = "no steps were read from the trace";

        // Second reset clears x1 and x2, so both operands read zero
        if (fail_reason == "") begin
            wait_clk(1'b1, ok);
            reset       <= 1'b1;
            busy        <= 1'b0;
            instruction <= ADD_X3_X1_X2;
            for (int c = 0; c < RESET_CYCLES && ok; c++)
                wait_clk(1'b1, ok);
            reset <= 1'b0;
            if (ok)
                wait_clk(1'b0, ok);
            if (!ok) begin
                fail_reason = "timeout while reset was applied again";
            end else begin
                step++;
                compare_word("alu_result", alu_result, '0, alu_ok);
                compare_word("store_data", store_data, '0, store_ok);
                $display("Step %0d: read after reset, instruction %h %s", step,
                         ADD_X3_X1_X2, (alu_ok && store_ok) ? "ok" : "mismatch");
            end
        end

        $display("Steps %0d, checks %0d, errors %0d", step, check_count, error_count);
        if (fail_reason != "")
            $display("Run stopped: %s", fail_reason);
        if (fail_reason == "" && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/rv_datapath_trace.txt ====
# instruction mem_data pc_plus4 busy expected_alu_result expected_store_data
# all hex, one cycle per line
002081B3 00000000 00000000 0 00000000 00000000
06400093 00000000 00000000 0 00000064 00000000
00700113 12345678 00000000 0 00000007 00000000
002081B3 00000000 00000000 0 0000006B 00000007
40208233 00000000 00000000 0 0000005D 00000007
0020F2B3 00000000 00000000 0 00000004 00000007
0020E333 00000000 00000000 0 00000067 00000007
0020C3B3 00000000 00000000 0 00000063 00000007
FFF00413 00000000 00000000 0 FFFFFFFF 00000000
001424B3 00000000 00000000 0 00000001 00000064
00209533 00000000 00000000 0 00003200 00000007
002455B3 00000000 00000000 0 01FFFFFF 00000007
00542613 00000000 00000000 0 00000001 00000000
FFD0A693 00000000 00000000 0 00000000 00000000
0080A703 CAFE0010 00000000 0 0000006C 00000000
002707B3 00000000 00000000 0 CAFE0017 00000007
0000086F 00000000 00001004 0 00000000 00000000
00080893 00000000 00000000 0 00001004 00000000
0030A623 00000000 00000000 0 00000070 0000006B
00C00933 00000000 00000000 0 00000001 00000001
003100B3 00000000 00000000 1 00000000 00000000
001009B3 00000000 00000000 0 00000064 00000064
00508013 00000000 00000000 0 00000069 00000000
00008A33 00000000 00000000 0 00000064 00000000

// ==== rv_datapath.f ====
+incdir+include
source/rv_pkg.sv
source/regfile_if.sv
source/instr_decoder.sv
source/register_file.sv
source/alu.sv
source/rv_datapath.sv
bench/clock_gen.sv
bench/rv_datapath_asserts.sv
bench/rv_datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_datapath_tb -f rv_datapath.f

./obj_dir/Vrv_datapath_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1
